// ==== Makefile ====
# Verilator flow for the decode front end

VERILATOR ?= verilator
TOP       ?= tb_decode_front
LINT_TOP  ?= decode_front
FILELIST  ?= decode_front.f
BUILD_DIR ?= obj_dir
SEED_ARGS ?= +verilator+seed+1
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only -Wall --timing

PASS_TEXT := All tests passed!

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# the status of the pipeline is the status of grep, so a missing pass line fails
run: build
	./$(BUILD_DIR)/V$(TOP) $(SEED_ARGS) | tee /dev/stderr | grep -F "$(PASS_TEXT)" > /dev/null

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(LINT_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

// ==== decode_front.f ====
design/decode_pkg.sv
design/id_bundle_if.sv
design/id1_decoder.sv
design/issue_id2.sv
design/id2_operand_read.sv
design/decode_front.sv
tb/decode_front_sva.sv
tb/tb_decode_front.sv

// ==== design/decode_front.sv ====
`timescale 1ns/1ps

module decode_front import decode_pkg::*; #(
    parameter bit WB_BYPASS = 1'b1
) (
    input  logic              clk,
    input  logic              arst_n_i,
    input  logic              stall_i,
    input  logic              flush_i,
    input  logic              inst_valid_i,
    input  logic [XLEN-1:0]   inst_i,
    input  logic [XLEN-1:0]   pc_i,
    input  logic              wb_we_i,
    input  logic [REG_AW-1:0] wb_addr_i,
    input  logic [XLEN-1:0]   wb_data_i,
    output logic              ex_valid_o,
    output op_e               ex_op_o,
    output logic [XLEN-1:0]   ex_src_a_o,
    output logic [XLEN-1:0]   ex_src_b_o,
    output logic              ex_w_reg_ena_o,
    output logic [REG_AW-1:0] ex_w_reg_dst_o,
    output logic              ex_is_branch_o,
    output logic              ex_is_ls_o,
    output logic [XLEN-1:0]   ex_target_o,
    output logic [XLEN-1:0]   ex_pc_o
);

    id_bundle_if id1_if ();
    id_bundle_if id2_if ();

    id1_decoder u_id1_decoder (
        .inst_valid_i (inst_valid_i),
        .inst_i       (inst_i),
        .pc_i         (pc_i),
        .bundle_o     (id1_if.producer)
    );

    // the stage register that splits decode in two
    issue_id2 u_issue_id2 (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .stall_i  (stall_i),
        .flush_i  (flush_i),
        .in_i     (id1_if.consumer),
        .out_o    (id2_if.producer)
    );

    id2_operand_read #(
        .WB_BYPASS (WB_BYPASS)
    ) u_id2_operand_read (
        .clk            (clk),
        .arst_n_i       (arst_n_i),
        .stall_i        (stall_i),
        .flush_i        (flush_i),
        .in_i           (id2_if.consumer),
        .wb_we_i        (wb_we_i),
        .wb_addr_i      (wb_addr_i),
        .wb_data_i      (wb_data_i),
        .ex_valid_o     (ex_valid_o),
        .ex_op_o        (ex_op_o),
        .ex_src_a_o     (ex_src_a_o),
        .ex_src_b_o     (ex_src_b_o),
        .ex_w_reg_ena_o (ex_w_reg_ena_o),
        .ex_w_reg_dst_o (ex_w_reg_dst_o),
        .ex_is_branch_o (ex_is_branch_o),
        .ex_is_ls_o     (ex_is_ls_o),
        .ex_target_o    (ex_target_o),
        .ex_pc_o        (ex_pc_o)
    );

endmodule

// ==== design/decode_pkg.sv ====
package decode_pkg;

    // datapath and register file geometry
    localparam int XLEN   = 32;
    localparam int REG_AW = 5;
    localparam int IMM_W  = 16;
    localparam int JIMM_W = 26;

    // internal opcode after classification, OP_NOP must stay at zero
    // so that an all-zero bundle is a bubble
    typedef enum logic [4:0] {
        OP_NOP,
        OP_ADDU,
        OP_SUBU,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_SLT,
        OP_SLL,
        OP_SRL,
        OP_ADDIU,
        OP_ANDI,
        OP_ORI,
        OP_LUI,
        OP_LW,
        OP_SW,
        OP_BEQ,
        OP_BNE,
        OP_J,
        OP_JR
    } op_e;

    // decoded instruction as it travels from id1 to id2
    typedef struct packed {
        op_e               op;
        logic [XLEN-1:0]   pc;
        logic [XLEN-1:0]   inst;
        logic [REG_AW-1:0] rs;
        logic [REG_AW-1:0] rt;
        logic [REG_AW-1:0] rd;
        logic [REG_AW-1:0] sa;
        logic              w_reg_ena;
        logic [REG_AW-1:0] w_reg_dst;
        logic [IMM_W-1:0]  imme;
        logic [JIMM_W-1:0] j_imme;
        logic              is_branch;
        logic              is_j_imme;
        logic              is_jr;
        logic              is_ls;
    } decoded_t;

    localparam decoded_t BUBBLE = '0;

endpackage

// ==== design/id1_decoder.sv ====
`timescale 1ns/1ps

module id1_decoder import decode_pkg::*; (
    input  logic            inst_valid_i,
    input  logic [XLEN-1:0] inst_i,
    input  logic [XLEN-1:0] pc_i,
    id_bundle_if.producer   bundle_o
);

    // primary opcode field
    localparam logic [5:0] OPC_SPECIAL = 6'h00;
    localparam logic [5:0] OPC_J       = 6'h02;
    localparam logic [5:0] OPC_BEQ     = 6'h04;
    localparam logic [5:0] OPC_BNE     = 6'h05;
    localparam logic [5:0] OPC_ADDIU   = 6'h09;
    localparam logic [5:0] OPC_ANDI    = 6'h0c;
    localparam logic [5:0] OPC_ORI     = 6'h0d;
    localparam logic [5:0] OPC_LUI     = 6'h0f;
    localparam logic [5:0] OPC_LW      = 6'h23;
    localparam logic [5:0] OPC_SW      = 6'h2b;

    // function field of SPECIAL words
    localparam logic [5:0] FN_SLL  = 6'h00;
    localparam logic [5:0] FN_SRL  = 6'h02;
    localparam logic [5:0] FN_JR   = 6'h08;
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_XOR  = 6'h26;
    localparam logic [5:0] FN_SLT  = 6'h2a;

    logic [5:0]        opcode;
    logic [5:0]        funct;
    logic [REG_AW-1:0] dst;
    logic              writes_reg;
    op_e               op;
    decoded_t          dec;

    assign opcode = inst_i[31:26];
    assign funct  = inst_i[5:0];

    always_comb begin
        case (opcode)
            OPC_SPECIAL: begin
                case (funct)
                    FN_ADDU: op = OP_ADDU;
                    FN_SUBU: op = OP_SUBU;
                    FN_AND:  op = OP_AND;
                    FN_OR:   op = OP_OR;
                    FN_XOR:  op = OP_XOR;
                    FN_SLT:  op = OP_SLT;
                    FN_SLL:  op = OP_SLL;
                    FN_SRL:  op = OP_SRL;
                    FN_JR:   op = OP_JR;
                    default: op = OP_NOP;
                endcase
            end
            OPC_J:     op = OP_J;
            OPC_BEQ:   op = OP_BEQ;
            OPC_BNE:   op = OP_BNE;
            OPC_ADDIU: op = OP_ADDIU;
            OPC_ANDI:  op = OP_ANDI;
            OPC_ORI:   op = OP_ORI;
            OPC_LUI:   op = OP_LUI;
            OPC_LW:    op = OP_LW;
            OPC_SW:    op = OP_SW;
            default:   op = OP_NOP;
        endcase
    end

    always_comb begin
        case (op)
            OP_ADDU, OP_SUBU, OP_AND, OP_OR, OP_XOR, OP_SLT, OP_SLL, OP_SRL,
            OP_ADDIU, OP_ANDI, OP_ORI, OP_LUI, OP_LW: writes_reg = 1'b1;
            default:                                   writes_reg = 1'b0;
        endcase
    end

    // the destination follows the word format, even for ops that do not write
    assign dst = (opcode == OPC_SPECIAL) ? inst_i[15:11] : inst_i[20:16];

    always_comb begin
        dec.op        = op;
        dec.pc        = pc_i;
        dec.inst      = inst_i;
        dec.rs        = inst_i[25:21];
        dec.rt        = inst_i[20:16];
        dec.rd        = inst_i[15:11];
        dec.sa        = inst_i[10:6];
        dec.imme      = inst_i[IMM_W-1:0];
        dec.j_imme    = inst_i[JIMM_W-1:0];
        dec.w_reg_dst = dst;
        // writes to register 0 are dropped here so later stages never see them
        dec.w_reg_ena = writes_reg && (dst != '0);
        dec.is_branch = (op == OP_BEQ) || (op == OP_BNE);
        dec.is_j_imme = (op == OP_J);
        dec.is_jr     = (op == OP_JR);
        dec.is_ls     = (op == OP_LW) || (op == OP_SW);
    end

    assign bundle_o.valid  = inst_valid_i;
    assign bundle_o.bundle = dec;

endmodule

// ==== design/id2_operand_read.sv ====
`timescale 1ns/1ps

module id2_operand_read import decode_pkg::*; #(
    parameter bit WB_BYPASS = 1'b1
) (
    input  logic              clk,
    input  logic              arst_n_i,
    input  logic              stall_i,
    input  logic              flush_i,
    id_bundle_if.consumer     in_i,
    input  logic              wb_we_i,
    input  logic [REG_AW-1:0] wb_addr_i,
    input  logic [XLEN-1:0]   wb_data_i,
    output logic              ex_valid_o,
    output op_e               ex_op_o,
    output logic [XLEN-1:0]   ex_src_a_o,
    output logic [XLEN-1:0]   ex_src_b_o,
    output logic              ex_w_reg_ena_o,
    output logic [REG_AW-1:0] ex_w_reg_dst_o,
    output logic              ex_is_branch_o,
    output logic              ex_is_ls_o,
    output logic [XLEN-1:0]   ex_target_o,
    output logic [XLEN-1:0]   ex_pc_o
);

    localparam int NREGS = 2 ** REG_AW;

    // register 0 is hardwired, so only 1..31 are stored
    logic [XLEN-1:0] rf_q [NREGS-1:1];
    decoded_t        b;
    logic [XLEN-1:0] rs_val;
    logic [XLEN-1:0] rt_val;
    logic [XLEN-1:0] imm_sext;
    logic [XLEN-1:0] imm_zext;
    logic [XLEN-1:0] pc_plus4;
    logic [XLEN-1:0] src_b;
    logic [XLEN-1:0] target;

    assign b = in_i.bundle;

    // writes continue during stall, write-back is not part of this pipeline
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 1; i < NREGS; i++) begin
                rf_q[i] <= '0;
            end
        end else if (wb_we_i && (wb_addr_i != '0)) begin
            rf_q[wb_addr_i] <= wb_data_i;
        end
    end

    function automatic logic [XLEN-1:0] read_reg(input logic [REG_AW-1:0] addr);
        logic [XLEN-1:0] val;
        if (addr == '0) begin
            val = '0;
        end else if (WB_BYPASS && wb_we_i && (wb_addr_i == addr)) begin
            val = wb_data_i;
        end else begin
            val = rf_q[addr];
        end
        return val;
    endfunction

    always_comb begin
        rs_val = read_reg(b.rs);
        rt_val = read_reg(b.rt);
    end

    assign imm_sext = {{(XLEN-IMM_W){b.imme[IMM_W-1]}}, b.imme};
    assign imm_zext = {{(XLEN-IMM_W){1'b0}}, b.imme};
    assign pc_plus4 = b.pc + XLEN'(4);

    always_comb begin
        case (b.op)
            OP_SLL, OP_SRL:                    src_b = {{(XLEN-REG_AW){1'b0}}, b.sa};
            OP_ADDU, OP_SUBU, OP_AND, OP_OR,
            OP_XOR, OP_SLT, OP_BEQ, OP_BNE:    src_b = rt_val;
            OP_ANDI, OP_ORI:                   src_b = imm_zext;
            OP_ADDIU, OP_LW, OP_SW:            src_b = imm_sext;
            OP_LUI:                            src_b = {b.imme, {(XLEN-IMM_W){1'b0}}};
            default:                           src_b = '0;
        endcase
    end

    always_comb begin
        if (b.is_branch) begin
            target = pc_plus4 + {imm_sext[XLEN-3:0], 2'b00};
        end else if (b.is_j_imme) begin
            target = {pc_plus4[XLEN-1:JIMM_W+2], b.j_imme, 2'b00};
        end else if (b.is_jr) begin
            target = rs_val;
        end else begin
            target = '0;
        end
    end

    // a bubble in id2 is all zero, so it lands here as all-zero ex_ fields
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ex_valid_o     <= 1'b0;
            ex_op_o        <= OP_NOP;
            ex_src_a_o     <= '0;
            ex_src_b_o     <= '0;
            ex_w_reg_ena_o <= 1'b0;
            ex_w_reg_dst_o <= '0;
            ex_is_branch_o <= 1'b0;
            ex_is_ls_o     <= 1'b0;
            ex_target_o    <= '0;
            ex_pc_o        <= '0;
        end else if (!stall_i) begin
            if (flush_i) begin
                ex_valid_o     <= 1'b0;
                ex_op_o        <= OP_NOP;
                ex_src_a_o     <= '0;
                ex_src_b_o     <= '0;
                ex_w_reg_ena_o <= 1'b0;
                ex_w_reg_dst_o <= '0;
                ex_is_branch_o <= 1'b0;
                ex_is_ls_o     <= 1'b0;
                ex_target_o    <= '0;
                ex_pc_o        <= '0;
            end else begin
                ex_valid_o     <= in_i.valid;
                ex_op_o        <= b.op;
                ex_src_a_o     <= rs_val;
                ex_src_b_o     <= src_b;
                ex_w_reg_ena_o <= b.w_reg_ena;
                ex_w_reg_dst_o <= b.w_reg_dst;
                ex_is_branch_o <= b.is_branch;
                ex_is_ls_o     <= b.is_ls;
                ex_target_o    <= target;
                ex_pc_o        <= b.pc;
            end
        end
    end

endmodule

// ==== design/id_bundle_if.sv ====
`timescale 1ns/1ps

// decoded bundle between the two decode stages, valid low means bubble
interface id_bundle_if import decode_pkg::*; ();

    logic     valid;
    decoded_t bundle;

    modport producer (
        output valid,
        output bundle
    );

    modport consumer (
        input valid,
        input bundle
    );

endinterface

// ==== design/issue_id2.sv ====
`timescale 1ns/1ps

module issue_id2 import decode_pkg::*; (
    input  logic          clk,
    input  logic          arst_n_i,
    input  logic          stall_i,
    input  logic          flush_i,
    id_bundle_if.consumer in_i,
    id_bundle_if.producer out_o
);

    logic     valid_q;
    decoded_t bundle_q;

    // stall holds the slot, otherwise flush or an empty id1 slot loads a bubble
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q  <= 1'b0;
            bundle_q <= BUBBLE;
        end else if (!stall_i) begin
            if (flush_i || !in_i.valid) begin
                valid_q  <= 1'b0;
                bundle_q <= BUBBLE;
            end else begin
                valid_q  <= 1'b1;
                bundle_q <= in_i.bundle;
            end
        end
    end

    assign out_o.valid  = valid_q;
    assign out_o.bundle = bundle_q;

endmodule

// ==== tb/decode_front_sva.sv ====
`timescale 1ns/1ps

module decode_front_sva import decode_pkg::*; (
    input logic              clk,
    input logic              arst_n_i,
    input logic              stall_i,
    input logic              flush_i,
    input logic              ex_valid_o,
    input op_e               ex_op_o,
    input logic [XLEN-1:0]   ex_src_a_o,
    input logic [XLEN-1:0]   ex_src_b_o,
    input logic              ex_w_reg_ena_o,
    input logic [REG_AW-1:0] ex_w_reg_dst_o,
    input logic              ex_is_branch_o,
    input logic              ex_is_ls_o,
    input logic [XLEN-1:0]   ex_target_o,
    input logic [XLEN-1:0]   ex_pc_o
);

    // no instruction may leave decode while reset is held
    a_reset_quiet : assert property (@(posedge clk) !arst_n_i |-> !ex_valid_o)
        else $error("ex_valid_o high while reset is active");

    // a stalled edge leaves the execute side untouched
    a_stall_hold : assert property (@(posedge clk) disable iff (!arst_n_i)
        stall_i |=> $stable(ex_valid_o) && $stable(ex_op_o) && $stable(ex_src_a_o)
            && $stable(ex_src_b_o) && $stable(ex_w_reg_ena_o) && $stable(ex_w_reg_dst_o)
            && $stable(ex_is_branch_o) && $stable(ex_is_ls_o)
            && $stable(ex_target_o) && $stable(ex_pc_o))
        else $error("ex_ outputs changed after a stalled edge");

    a_flush_clear : assert property (@(posedge clk) disable iff (!arst_n_i)
        (flush_i && !stall_i) |=> !ex_valid_o)
        else $error("ex_valid_o high after a flush");

    // register 0 writes are dropped in id1
    a_no_r0_write : assert property (@(posedge clk) disable iff (!arst_n_i)
        ex_w_reg_ena_o |-> (ex_w_reg_dst_o != '0))
        else $error("write enable set with register 0 as destination");

endmodule

bind decode_front decode_front_sva sva0 (
    .clk            (clk),
    .arst_n_i       (arst_n_i),
    .stall_i        (stall_i),
    .flush_i        (flush_i),
    .ex_valid_o     (ex_valid_o),
    .ex_op_o        (ex_op_o),
    .ex_src_a_o     (ex_src_a_o),
    .ex_src_b_o     (ex_src_b_o),
    .ex_w_reg_ena_o (ex_w_reg_ena_o),
    .ex_w_reg_dst_o (ex_w_reg_dst_o),
    .ex_is_branch_o (ex_is_branch_o),
    .ex_is_ls_o     (ex_is_ls_o),
    .ex_target_o    (ex_target_o),
    .ex_pc_o        (ex_pc_o)
);

// ==== tb/tb_decode_front.sv ====
`timescale 1ns/1ps

module tb_decode_front import decode_pkg::*; ();

    localparam int unsigned SEED         = 32'hdcd7c036;
    localparam int          PERIOD       = 100;
    localparam int          RESET_CYCLES = 10;
    localparam int          NUM_CYCLES   = 4000;
    localparam int          WATCHDOG_NS  = (NUM_CYCLES + 100) * PERIOD;
    localparam bit          WB_BYPASS    = 1'b1;

    // percentages for the random control inputs
    localparam int STALL_PCT = 20;
    localparam int FLUSH_PCT = 10;
    localparam int VALID_PCT = 85;
    localparam int WB_PCT    = 50;

    localparam logic [5:0] OPC_SPECIAL = 6'h00;
    localparam logic [5:0] OPC_J       = 6'h02;
    localparam logic [5:0] OPC_BEQ     = 6'h04;
    localparam logic [5:0] OPC_BNE     = 6'h05;
    localparam logic [5:0] OPC_ADDIU   = 6'h09;
    localparam logic [5:0] OPC_ANDI    = 6'h0c;
    localparam logic [5:0] OPC_ORI     = 6'h0d;
    localparam logic [5:0] OPC_LUI     = 6'h0f;
    localparam logic [5:0] OPC_LW      = 6'h23;
    localparam logic [5:0] OPC_SW      = 6'h2b;
    localparam logic [5:0] FN_SLL      = 6'h00;
    localparam logic [5:0] FN_SRL      = 6'h02;
    localparam logic [5:0] FN_JR       = 6'h08;
    localparam logic [5:0] FN_ADDU     = 6'h21;
    localparam logic [5:0] FN_SUBU     = 6'h23;
    localparam logic [5:0] FN_AND      = 6'h24;
    localparam logic [5:0] FN_OR       = 6'h25;
    localparam logic [5:0] FN_XOR      = 6'h26;
    localparam logic [5:0] FN_SLT      = 6'h2a;

    // expected state of the ex_ output register
    typedef struct packed {
        logic              valid;
        op_e               op;
        logic [XLEN-1:0]   src_a;
        logic [XLEN-1:0]   src_b;
        logic              w_reg_ena;
        logic [REG_AW-1:0] w_reg_dst;
        logic              is_branch;
        logic              is_ls;
        logic [XLEN-1:0]   target;
        logic [XLEN-1:0]   pc;
    } ex_t;

    logic              clk;
    logic              arst_n_i;
    logic              stall_i;
    logic              flush_i;
    logic              inst_valid_i;
    logic [XLEN-1:0]   inst_i;
    logic [XLEN-1:0]   pc_i;
    logic              wb_we_i;
    logic [REG_AW-1:0] wb_addr_i;
    logic [XLEN-1:0]   wb_data_i;
    logic              ex_valid_o;
    op_e               ex_op_o;
    logic [XLEN-1:0]   ex_src_a_o;
    logic [XLEN-1:0]   ex_src_b_o;
    logic              ex_w_reg_ena_o;
    logic [REG_AW-1:0] ex_w_reg_dst_o;
    logic              ex_is_branch_o;
    logic              ex_is_ls_o;
    logic [XLEN-1:0]   ex_target_o;
    logic [XLEN-1:0]   ex_pc_o;

    logic [XLEN-1:0] rf_m [0:31];
    logic            id2_valid_m;
    decoded_t        id2_m;
    ex_t             ex_m;
    int              cycle_no;
    int              error_count;

    decode_front #(
        .WB_BYPASS (WB_BYPASS)
    ) dut0 (
        .clk            (clk),
        .arst_n_i       (arst_n_i),
        .stall_i        (stall_i),
        .flush_i        (flush_i),
        .inst_valid_i   (inst_valid_i),
        .inst_i         (inst_i),
        .pc_i           (pc_i),
        .wb_we_i        (wb_we_i),
        .wb_addr_i      (wb_addr_i),
        .wb_data_i      (wb_data_i),
        .ex_valid_o     (ex_valid_o),
        .ex_op_o        (ex_op_o),
        .ex_src_a_o     (ex_src_a_o),
        .ex_src_b_o     (ex_src_b_o),
        .ex_w_reg_ena_o (ex_w_reg_ena_o),
        .ex_w_reg_dst_o (ex_w_reg_dst_o),
        .ex_is_branch_o (ex_is_branch_o),
        .ex_is_ls_o     (ex_is_ls_o),
        .ex_target_o    (ex_target_o),
        .ex_pc_o        (ex_pc_o)
    );

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    task automatic stop_with_failure();
        error_count++;
        $display("Test failures found");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the run did not finish within %0d cycles", NUM_CYCLES + 100);
        stop_with_failure();
    end

    task automatic compare_op(input string name, input op_e exp, input op_e act);
        if (act !== exp) begin
            $display("MISMATCH %s cycle %0d: expected %s actual %s",
                     name, cycle_no, exp.name(), act.name());
            stop_with_failure();
        end
    endtask

    task automatic compare_word(input string name, input logic [XLEN-1:0] exp,
                                input logic [XLEN-1:0] act);
        if (act !== exp) begin
            $display("MISMATCH %s cycle %0d: expected %h actual %h", name, cycle_no, exp, act);
            stop_with_failure();
        end
    endtask

    task automatic compare_reg(input string name, input logic [REG_AW-1:0] exp,
                               input logic [REG_AW-1:0] act);
        if (act !== exp) begin
            $display("MISMATCH %s cycle %0d: expected %0d actual %0d", name, cycle_no, exp, act);
            stop_with_failure();
        end
    endtask

    task automatic compare_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("MISMATCH %s cycle %0d: expected %b actual %b", name, cycle_no, exp, act);
            stop_with_failure();
        end
    endtask

    task automatic check_outputs(input string test);
        compare_bit({test, ".ex_valid"}, ex_m.valid, ex_valid_o);
        compare_op({test, ".ex_op"}, ex_m.op, ex_op_o);
        compare_word({test, ".ex_src_a"}, ex_m.src_a, ex_src_a_o);
        compare_word({test, ".ex_src_b"}, ex_m.src_b, ex_src_b_o);
        compare_bit({test, ".ex_w_reg_ena"}, ex_m.w_reg_ena, ex_w_reg_ena_o);
        compare_reg({test, ".ex_w_reg_dst"}, ex_m.w_reg_dst, ex_w_reg_dst_o);
        compare_bit({test, ".ex_is_branch"}, ex_m.is_branch, ex_is_branch_o);
        compare_bit({test, ".ex_is_ls"}, ex_m.is_ls, ex_is_ls_o);
        compare_word({test, ".ex_target"}, ex_m.target, ex_target_o);
        compare_word({test, ".ex_pc"}, ex_m.pc, ex_pc_o);
    endtask

    function automatic decoded_t decode_word(input logic [XLEN-1:0] w,
                                             input logic [XLEN-1:0] pc);
        decoded_t d;
        logic     writes;
        d        = '0;
        d.pc     = pc;
        d.inst   = w;
        d.rs     = w[25:21];
        d.rt     = w[20:16];
        d.rd     = w[15:11];
        d.sa     = w[10:6];
        d.imme   = w[15:0];
        d.j_imme = w[25:0];
        case (w[31:26])
            OPC_SPECIAL: begin
                case (w[5:0])
                    FN_ADDU: d.op = OP_ADDU;
                    FN_SUBU: d.op = OP_SUBU;
                    FN_AND:  d.op = OP_AND;
                    FN_OR:   d.op = OP_OR;
                    FN_XOR:  d.op = OP_XOR;
                    FN_SLT:  d.op = OP_SLT;
                    FN_SLL:  d.op = OP_SLL;
                    FN_SRL:  d.op = OP_SRL;
                    FN_JR:   d.op = OP_JR;
                    default: d.op = OP_NOP;
                endcase
            end
            OPC_J:     d.op = OP_J;
            OPC_BEQ:   d.op = OP_BEQ;
            OPC_BNE:   d.op = OP_BNE;
            OPC_ADDIU: d.op = OP_ADDIU;
            OPC_ANDI:  d.op = OP_ANDI;
            OPC_ORI:   d.op = OP_ORI;
            OPC_LUI:   d.op = OP_LUI;
            OPC_LW:    d.op = OP_LW;
            OPC_SW:    d.op = OP_SW;
            default:   d.op = OP_NOP;
        endcase
        writes = d.op inside {OP_ADDU, OP_SUBU, OP_AND, OP_OR, OP_XOR, OP_SLT, OP_SLL,
                              OP_SRL, OP_ADDIU, OP_ANDI, OP_ORI, OP_LUI, OP_LW};
        d.w_reg_dst = (w[31:26] == OPC_SPECIAL) ? w[15:11] : w[20:16];
        d.w_reg_ena = writes && (d.w_reg_dst != '0);
        d.is_branch = (d.op == OP_BEQ) || (d.op == OP_BNE);
        d.is_j_imme = (d.op == OP_J);
        d.is_jr     = (d.op == OP_JR);
        d.is_ls     = (d.op == OP_LW) || (d.op == OP_SW);
        return d;
    endfunction

    // read as seen before the edge, with the same-cycle write forwarded
    function automatic logic [XLEN-1:0] read_model(input logic [REG_AW-1:0] addr);
        if (addr == '0) begin
            return '0;
        end
        if (WB_BYPASS && wb_we_i && (wb_addr_i == addr)) begin
            return wb_data_i;
        end
        return rf_m[addr];
    endfunction

    function automatic ex_t next_ex(input logic valid, input decoded_t d);
        ex_t             e;
        logic [XLEN-1:0] rs_v;
        logic [XLEN-1:0] sext;
        logic [XLEN-1:0] pc4;
        rs_v        = read_model(d.rs);
        sext        = {{16{d.imme[15]}}, d.imme};
        pc4         = d.pc + 32'd4;
        e           = '0;
        e.valid     = valid;
        e.op        = d.op;
        e.src_a     = rs_v;
        e.w_reg_ena = d.w_reg_ena;
        e.w_reg_dst = d.w_reg_dst;
        e.is_branch = d.is_branch;
        e.is_ls     = d.is_ls;
        e.pc        = d.pc;
        case (d.op)
            OP_SLL, OP_SRL:          e.src_b = {27'd0, d.sa};
            OP_ADDU, OP_SUBU, OP_AND, OP_OR, OP_XOR, OP_SLT, OP_BEQ, OP_BNE:
                                     e.src_b = read_model(d.rt);
            OP_ANDI, OP_ORI:         e.src_b = {16'd0, d.imme};
            OP_ADDIU, OP_LW, OP_SW:  e.src_b = sext;
            OP_LUI:                  e.src_b = {d.imme, 16'd0};
            default:                 e.src_b = '0;
        endcase
        case (d.op)
            OP_BEQ, OP_BNE: e.target = pc4 + (sext << 2);
            OP_J:           e.target = {pc4[31:28], d.j_imme, 2'b00};
            OP_JR:          e.target = rs_v;
            default:        e.target = '0;
        endcase
        return e;
    endfunction

    // advance the model across the coming rising edge
    task automatic model_step();
        if (!stall_i) begin
            if (flush_i) begin
                ex_m = '0;
            end else begin
                ex_m = next_ex(id2_valid_m, id2_m);
            end
            if (flush_i || !inst_valid_i) begin
                id2_valid_m = 1'b0;
                id2_m       = '0;
            end else begin
                id2_valid_m = 1'b1;
                id2_m       = decode_word(inst_i, pc_i);
            end
        end
        if (wb_we_i && (wb_addr_i != '0)) begin
            rf_m[wb_addr_i] = wb_data_i;
        end
    endtask

    // mostly low registers, so reads and write-backs collide often
    function automatic logic [REG_AW-1:0] rand_reg();
        if ($urandom_range(3) == 0) begin
            return REG_AW'($urandom_range(31));
        end
        return REG_AW'($urandom_range(7));
    endfunction

    function automatic logic [XLEN-1:0] r_word(input logic [5:0] fn);
        return {OPC_SPECIAL, rand_reg(), rand_reg(), rand_reg(), 5'($urandom_range(31)), fn};
    endfunction

    function automatic logic [XLEN-1:0] i_word(input logic [5:0] opc);
        return {opc, rand_reg(), rand_reg(), 16'($urandom)};
    endfunction

    function automatic logic [XLEN-1:0] rand_inst();
        case ($urandom_range(19))
            0:       return r_word(FN_ADDU);
            1:       return r_word(FN_SUBU);
            2:       return r_word(FN_AND);
            3:       return r_word(FN_OR);
            4:       return r_word(FN_XOR);
            5:       return r_word(FN_SLT);
            6:       return r_word(FN_SLL);
            7:       return r_word(FN_SRL);
            8:       return {OPC_SPECIAL, rand_reg(), 15'd0, FN_JR};
            9:       return i_word(OPC_ADDIU);
            10:      return i_word(OPC_ANDI);
            11:      return i_word(OPC_ORI);
            12:      return i_word(OPC_LUI);
            13:      return i_word(OPC_LW);
            14:      return i_word(OPC_SW);
            15:      return i_word(OPC_BEQ);
            16:      return i_word(OPC_BNE);
            17:      return {OPC_J, 26'($urandom)};
            default: return $urandom;
        endcase
    endfunction

    task automatic drive_inputs();
        logic hold_inst;
        // fetch keeps an instruction that met a stalled edge
        hold_inst = stall_i;
        stall_i   = ($urandom_range(99) < STALL_PCT);
        flush_i   = ($urandom_range(99) < FLUSH_PCT);
        if (!hold_inst) begin
            inst_valid_i = ($urandom_range(99) < VALID_PCT);
            inst_i       = rand_inst();
            pc_i         = $urandom & 32'hffff_fffc;
        end
        wb_we_i   = ($urandom_range(99) < WB_PCT);
        wb_addr_i = rand_reg();
        wb_data_i = $urandom;
    endtask

    initial begin
        void'($urandom(SEED));
        arst_n_i     = 1'b0;
        stall_i      = 1'b0;
        flush_i      = 1'b0;
        inst_valid_i = 1'b0;
        inst_i       = '0;
        pc_i         = '0;
        wb_we_i      = 1'b0;
        wb_addr_i    = '0;
        wb_data_i    = '0;
        error_count  = 0;
        cycle_no     = 0;
        id2_valid_m  = 1'b0;
        id2_m        = '0;
        ex_m         = '0;
        for (int i = 0; i < 32; i++) begin
            rf_m[i] = '0;
        end

        repeat (RESET_CYCLES) @(negedge clk);
        check_outputs("reset");
        arst_n_i = 1'b1;

        for (cycle_no = 1; cycle_no <= NUM_CYCLES; cycle_no++) begin
            drive_inputs();
            model_step();
            @(negedge clk);
            check_outputs("random_decode");
        end

        if (error_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule
